// ==== hw/rg_pkg.sv ====
package rg_pkg;

    // ****************************************
    // shared widths.
    // ****************************************

    typedef logic [3:0]  arrow_t;     // up, down, left, right from msb.
    typedef logic [3:0]  lane_t;      // one bit per note lane.
    typedef logic [2:0]  chart_id_t;
    typedef logic [3:0]  step_t;
    typedef logic [4:0]  score_t;
    typedef logic [63:0] seg_label_t; // eight ascii characters.

    // top-level page.
    typedef enum logic [1:0] {
        menu_page,
        play_page,
        history_page
    } top_state_t;

    // ****************************************
    // sizes and timing.
    // ****************************************

    localparam int chart_len   = 16;
    localparam int num_charts  = 5;
    localparam int step_cycles = 4;  // prog_clk cycles per step.
    localparam int hist_depth  = 4;
    localparam int menu_rows   = 6;  // history row plus five charts.

    // ****************************************
    // arrow key codes.
    // ****************************************

    localparam arrow_t key_up    = 4'b1000;
    localparam arrow_t key_down  = 4'b0100;
    localparam arrow_t key_left  = 4'b0010;
    localparam arrow_t key_right = 4'b0001;

endpackage

// ==== hw/play_if.sv ====
`timescale 1ns/1ns

// start a chart run and collect its score.
interface play_if import rg_pkg::*; ();

    logic      start;      // pulse, only while the player is idle.
    logic      auto_play;
    chart_id_t chart_id;
    logic      done;       // one pulse per start.
    score_t    score;      // valid with done.

    modport ctrl (
        output start,
        output auto_play,
        output chart_id,
        input  done,
        input  score
    );

    modport player (
        input  start,
        input  auto_play,
        input  chart_id,
        output done,
        output score
    );

endinterface

// ==== hw/game_ctrl.sv ====
`timescale 1ns/1ns

module game_ctrl import rg_pkg::*; (
    input  logic       prog_clk,
    input  logic       rst,
    input  arrow_t     arrow_keys,
    output arrow_t     key_pulse,
    output logic       menu_active,
    output logic       hist_active,
    input  logic       go_play,
    input  logic       go_auto,
    input  logic       go_history,
    input  chart_id_t  chart_sel,
    play_if.ctrl       play,
    output top_state_t state,
    output score_t     last_score
);

    arrow_t prev_keys;

    // ****************************************
    // single key pulses.
    // ****************************************

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            prev_keys <= '0;
            key_pulse <= '0;
        end else begin
            prev_keys <= arrow_keys;
            // fresh press of exactly one key.
            if ($onehot(arrow_keys) && prev_keys == '0) begin
                key_pulse <= arrow_keys;
            end else begin
                key_pulse <= '0;
            end
        end
    end

    assign menu_active = (state == menu_page);
    assign hist_active = (state == history_page);

    // ****************************************
    // page state machine.
    // ****************************************

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            state          <= menu_page;
            play.start     <= 1'b0;
            play.auto_play <= 1'b0;
            last_score     <= '0;
        end else begin
            play.start <= 1'b0;
            case (state)
                menu_page: begin
                    if (go_play || go_auto) begin
                        state          <= play_page;
                        play.start     <= 1'b1;  // same cycle as play_page.
                        play.auto_play <= go_auto;
                    end else if (go_history) begin
                        state <= history_page;
                    end
                end
                play_page: begin
                    if (play.done) begin
                        state          <= menu_page;
                        play.auto_play <= 1'b0;
                        last_score     <= play.score;
                    end
                end
                default: begin
                    if (key_pulse == key_left) state <= menu_page;
                end
            endcase
        end
    end

    // chart follows the menu selection at start.
    always_ff @(posedge prog_clk) begin
        if (state == menu_page && (go_play || go_auto)) play.chart_id <= chart_sel;
    end

endmodule

// ==== hw/page_menu.sv ====
`timescale 1ns/1ns

module page_menu import rg_pkg::*; (
    input  logic       prog_clk,
    input  logic       rst,
    input  arrow_t     key_pulse,
    input  logic       active,
    output logic [2:0] cursor,
    output chart_id_t  chart_sel,
    output seg_label_t seg_label,
    output logic       go_play,
    output logic       go_auto,
    output logic       go_history
);

    localparam logic [2:0] last_row = 3'(menu_rows - 1);

    arrow_t key;

    // keys only count while the menu is shown.
    assign key = active ? key_pulse : '0;

    // row 0 is history and maps onto free play.
    assign chart_sel = (cursor == 3'd0) ? chart_id_t'(0) : chart_id_t'(cursor - 3'd1);

    // ****************************************
    // cursor movement.
    // ****************************************

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            cursor <= 3'd0;
        end else begin
            case (key)
                key_up: begin
                    if (cursor == 3'd0) cursor <= last_row;  // wrap to bottom.
                    else cursor <= cursor - 3'd1;
                end
                key_down: begin
                    // wraps past the history row.
                    if (cursor == last_row) cursor <= 3'd1;
                    else cursor <= cursor + 3'd1;
                end
                default: cursor <= cursor;
            endcase
        end
    end

    // ****************************************
    // choice pulses.
    // ****************************************

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            go_play    <= 1'b0;
            go_auto    <= 1'b0;
            go_history <= 1'b0;
        end else begin
            go_history <= (key == key_right) && (cursor == 3'd0);
            go_play    <= (key == key_right) && (cursor != 3'd0);
            go_auto    <= (key == key_left);
        end
    end

    // ****************************************
    // segment label, one cycle behind cursor.
    // ****************************************

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            seg_label <= "HIS     ";
        end else begin
            case (cursor)
                3'd0: seg_label <= "HIS     ";
                3'd1: seg_label <= "FREE    ";
                default: begin
                    // chart number as an ascii digit.
                    seg_label <= {"SO    0", 8'h30 + 8'(chart_sel)};
                end
            endcase
        end
    end

endmodule

// ==== hw/chart_rom.sv ====
`timescale 1ns/1ns

module chart_rom import rg_pkg::*; (
    input  chart_id_t rom_chart,
    input  step_t     rom_step,
    output lane_t     notes
);

    lane_t row [chart_len];

    // ****************************************
    // fixed charts, step 0 first.
    // ****************************************

    always_comb begin
        case (rom_chart)
            3'd1: begin
                // single lanes walking down.
                row = '{4'h8, 4'h0, 4'h4, 4'h0, 4'h2, 4'h0, 4'h1, 4'h0,
                        4'h8, 4'h0, 4'h4, 4'h0, 4'h2, 4'h0, 4'h1, 4'h0};
            end
            3'd2: begin
                row = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h0, 4'h0, 4'h9, 4'h0,
                        4'h6, 4'h0, 4'h3, 4'h0, 4'hc, 4'h0, 4'hf, 4'h0};
            end
            3'd3: begin
                // doubled notes with gaps.
                row = '{4'h8, 4'h8, 4'h0, 4'h4, 4'h4, 4'h0, 4'h2, 4'h2,
                        4'h0, 4'h1, 4'h1, 4'h0, 4'ha, 4'h5, 4'h0, 4'h0};
            end
            3'd4: begin
                row = '{4'hf, 4'h0, 4'h0, 4'h0, 4'h5, 4'ha, 4'h5, 4'ha,
                        4'h1, 4'h3, 4'h7, 4'hf, 4'h8, 4'hc, 4'he, 4'hf};
            end
            default: begin
                row = '{default: 4'h0};  // free play and unused ids.
            end
        endcase
    end

    assign notes = row[rom_step];

endmodule

// ==== hw/note_player.sv ====
`timescale 1ns/1ns

module note_player import rg_pkg::*; (
    input  logic      prog_clk,
    input  logic      rst,
    play_if.player    play,
    input  lane_t     hit_keys,
    output chart_id_t rom_chart,
    output step_t     rom_step,
    input  lane_t     notes,
    output logic      auto_play_led
);

    logic                           busy;
    logic                           auto_r;
    chart_id_t                      chart_r;
    step_t                          step_cnt;
    logic [$clog2(step_cycles)-1:0] cyc_cnt;
    score_t                         score_r;
    lane_t                          eff_hits;
    logic                           step_hit;
    logic                           step_end;

    assign rom_chart = chart_r;
    assign rom_step  = step_cnt;

    // auto mode hits exactly what the chart asks for.
    assign eff_hits = auto_r ? notes : hit_keys;
    assign step_hit = (notes != '0) && (eff_hits == notes);
    assign step_end = (int'(cyc_cnt) == step_cycles - 1);  // sample point.

    assign auto_play_led = busy && auto_r;
    assign play.score    = score_r;

    // ****************************************
    // run control and scoring.
    // ****************************************

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            busy      <= 1'b0;
            play.done <= 1'b0;
            step_cnt  <= '0;
            cyc_cnt   <= '0;
        end else begin
            play.done <= 1'b0;
            if (!busy) begin
                if (play.start) begin
                    busy     <= 1'b1;
                    step_cnt <= '0;
                    cyc_cnt  <= '0;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
                if (step_end) begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == step_t'(chart_len - 1)) begin
                        busy      <= 1'b0;
                        play.done <= 1'b1;  // one cycle after final step.
                    end
                end
            end
        end
    end

    always_ff @(posedge prog_clk) begin
        if (!busy && play.start) begin
            chart_r <= play.chart_id;
            auto_r  <= play.auto_play;
            score_r <= '0;
        end else if (busy && step_end && step_hit) begin
            score_r <= score_r + 1'b1;
        end
    end

endmodule

// ==== hw/score_history.sv ====
`timescale 1ns/1ns

module score_history import rg_pkg::*; (
    input  logic   prog_clk,
    input  logic   rst,
    input  logic   push,
    input  score_t push_score,
    input  arrow_t key_pulse,
    input  logic   active,
    output score_t hist_score
);

    score_t                        hist [hist_depth];
    logic [hist_depth-1:0]         filled;
    logic [$clog2(hist_depth)-1:0] rd_idx;

    // ****************************************
    // newest score enters at index 0.
    // ****************************************

    always_ff @(posedge prog_clk) begin
        if (push) begin
            hist[0] <= push_score;
            for (int i = 1; i < hist_depth; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            filled <= '0;
            rd_idx <= '0;
        end else begin
            if (push) filled <= {filled[hist_depth-2:0], 1'b1};
            if (active) begin
                // index wraps at the depth.
                if (key_pulse == key_down) rd_idx <= rd_idx + 1'b1;
                else if (key_pulse == key_up) rd_idx <= rd_idx - 1'b1;
            end
        end
    end

    assign hist_score = filled[rd_idx] ? hist[rd_idx] : '0;  // empty reads zero.

endmodule

// ==== hw/rhythm_top.sv ====
`timescale 1ns/1ns

module rhythm_top import rg_pkg::*; (
    input  logic       prog_clk,
    input  logic       rst,
    input  arrow_t     arrow_keys,
    input  lane_t      hit_keys,
    output top_state_t state,
    output logic [2:0] cursor,
    output seg_label_t seg_label,
    output logic       auto_play,
    output score_t     last_score,
    output score_t     hist_score
);

    arrow_t    key_pulse;
    logic      menu_active;
    logic      hist_active;
    logic      go_play;
    logic      go_auto;
    logic      go_history;
    chart_id_t chart_sel;
    chart_id_t rom_chart;
    step_t     rom_step;
    lane_t     notes;

    play_if u_play ();

    game_ctrl u_game_ctrl (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .arrow_keys  (arrow_keys),
        .key_pulse   (key_pulse),
        .menu_active (menu_active),
        .hist_active (hist_active),
        .go_play     (go_play),
        .go_auto     (go_auto),
        .go_history  (go_history),
        .chart_sel   (chart_sel),
        .play        (u_play.ctrl),
        .state       (state),
        .last_score  (last_score)
    );

    page_menu u_page_menu (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .key_pulse  (key_pulse),
        .active     (menu_active),
        .cursor     (cursor),
        .chart_sel  (chart_sel),
        .seg_label  (seg_label),
        .go_play    (go_play),
        .go_auto    (go_auto),
        .go_history (go_history)
    );

    chart_rom u_chart_rom (
        .rom_chart (rom_chart),
        .rom_step  (rom_step),
        .notes     (notes)
    );

    note_player u_note_player (
        .prog_clk      (prog_clk),
        .rst           (rst),
        .play          (u_play.player),
        .hit_keys      (hit_keys),
        .rom_chart     (rom_chart),
        .rom_step      (rom_step),
        .notes         (notes),
        .auto_play_led (auto_play)
    );

    // history stores each finished run.
    score_history u_score_history (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .push       (u_play.done),
        .push_score (u_play.score),
        .key_pulse  (key_pulse),
        .active     (hist_active),
        .hist_score (hist_score)
    );

endmodule

// ==== test/tb_rhythm_top.sv ====
`timescale 1ns/1ns

module tb_rhythm_top import rg_pkg::*; ();

    localparam int hits_none  = 0;
    localparam int hits_match = 1;
    localparam int hits_rand  = 2;

    typedef struct packed {
        arrow_t     key;
        int         mode;
        top_state_t st;
        logic [2:0] cur;
        seg_label_t lbl;
        int         score;  // -1 takes the model value.
    } entry_t;

    logic       prog_clk;
    logic       rst;
    arrow_t     arrow_keys;
    lane_t      hit_keys;
    top_state_t state;
    logic [2:0] cursor;
    seg_label_t seg_label;
    logic       auto_play;
    score_t     last_score;
    score_t     hist_score;

    entry_t tbl[$];
    lane_t  charts [num_charts][chart_len];
    int     hist_model [hist_depth];
    int     rd_model;
    int     exp_last;
    int     prev_cur;
    int     cycles = 0;

    rhythm_top u_rhythm_top (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .arrow_keys (arrow_keys),
        .hit_keys   (hit_keys),
        .state      (state),
        .cursor     (cursor),
        .seg_label  (seg_label),
        .auto_play  (auto_play),
        .last_score (last_score),
        .hist_score (hist_score)
    );

    initial begin
        prog_clk = 1'b0;
        forever #5 prog_clk = ~prog_clk;
    end

    // longest entry is one full chart run plus the key settle.
    always @(posedge prog_clk) begin
        cycles <= cycles + 1;
        if (cycles > tbl.size() * (chart_len * step_cycles + 20)) begin
            $display("Timeout: the run did not finish after %0d cycles", cycles);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    // ****************************************
    // reference charts and helpers.
    // ****************************************

    task automatic load_charts();
        charts[0] = '{default: 4'h0};
        charts[1] = '{4'h8, 4'h0, 4'h4, 4'h0, 4'h2, 4'h0, 4'h1, 4'h0,
                      4'h8, 4'h0, 4'h4, 4'h0, 4'h2, 4'h0, 4'h1, 4'h0};
        charts[2] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h0, 4'h0, 4'h9, 4'h0,
                      4'h6, 4'h0, 4'h3, 4'h0, 4'hc, 4'h0, 4'hf, 4'h0};
        charts[3] = '{4'h8, 4'h8, 4'h0, 4'h4, 4'h4, 4'h0, 4'h2, 4'h2,
                      4'h0, 4'h1, 4'h1, 4'h0, 4'ha, 4'h5, 4'h0, 4'h0};
        charts[4] = '{4'hf, 4'h0, 4'h0, 4'h0, 4'h5, 4'ha, 4'h5, 4'ha,
                      4'h1, 4'h3, 4'h7, 4'hf, 4'h8, 4'hc, 4'he, 4'hf};
    endtask

    function automatic int count_notes(input int n);
        int cnt;
        cnt = 0;
        for (int k = 0; k < chart_len; k++) begin
            if (charts[n][k] != '0) cnt++;
        end
        return cnt;
    endfunction

    function automatic void add_entry(input arrow_t key, input int mode, input top_state_t st,
                                      input logic [2:0] cur, input seg_label_t lbl,
                                      input int score);
        entry_t e;
        e.key   = key;
        e.mode  = mode;
        e.st    = st;
        e.cur   = cur;
        e.lbl   = lbl;
        e.score = score;
        tbl.push_back(e);
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp_val);
        if (got !== exp_val) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp_val);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic build_table();
        add_entry(key_up,    hits_none,  menu_page,    3'd5, "SO    04", -1);
        add_entry(key_down,  hits_none,  menu_page,    3'd1, "FREE    ", -1);  // wraps to 1.
        add_entry(key_down,  hits_none,  menu_page,    3'd2, "SO    01", -1);
        add_entry(key_up,    hits_none,  menu_page,    3'd1, "FREE    ", -1);
        add_entry(key_up,    hits_none,  menu_page,    3'd0, "HIS     ", -1);
        add_entry(4'b1100,   hits_none,  menu_page,    3'd0, "HIS     ", -1);  // two-hot.
        add_entry(key_right, hits_none,  history_page, 3'd0, "HIS     ", -1);
        add_entry(key_down,  hits_none,  history_page, 3'd0, "HIS     ", -1);
        add_entry(key_left,  hits_none,  menu_page,    3'd0, "HIS     ", -1);
        add_entry(key_left,  hits_none,  menu_page,    3'd0, "HIS     ", count_notes(0));
        add_entry(key_down,  hits_none,  menu_page,    3'd1, "FREE    ", -1);
        add_entry(key_down,  hits_none,  menu_page,    3'd2, "SO    01", -1);
        add_entry(key_left,  hits_none,  menu_page,    3'd2, "SO    01", count_notes(1));
        add_entry(key_down,  hits_none,  menu_page,    3'd3, "SO    02", -1);
        add_entry(key_right, hits_rand,  menu_page,    3'd3, "SO    02", -1);
        add_entry(key_down,  hits_none,  menu_page,    3'd4, "SO    03", -1);
        add_entry(key_right, hits_match, menu_page,    3'd4, "SO    03", count_notes(3));
        add_entry(key_down,  hits_none,  menu_page,    3'd5, "SO    04", -1);
        add_entry(key_left,  hits_none,  menu_page,    3'd5, "SO    04", count_notes(4));
        add_entry(key_right, hits_none,  menu_page,    3'd5, "SO    04", 0);
        add_entry(key_down,  hits_none,  menu_page,    3'd1, "FREE    ", -1);
        add_entry(key_up,    hits_none,  menu_page,    3'd0, "HIS     ", -1);
        add_entry(key_right, hits_none,  history_page, 3'd0, "HIS     ", -1);
        add_entry(key_up,    hits_none,  history_page, 3'd0, "HIS     ", -1);
        add_entry(key_up,    hits_none,  history_page, 3'd0, "HIS     ", -1);
        add_entry(key_down,  hits_none,  history_page, 3'd0, "HIS     ", -1);
        add_entry(key_down,  hits_none,  history_page, 3'd0, "HIS     ", -1);
        add_entry(key_left,  hits_none,  menu_page,    3'd0, "HIS     ", -1);
    endtask

    // ****************************************
    // one table entry, press to settle.
    // ****************************************

    task automatic run_entry(input entry_t e);
        int    c;
        int    pc;     // negedges since play_page was seen.
        int    run;
        int    chart;
        int    exp_score;
        lane_t note;
        logic  was_hist;
        logic  played;
        c        = 0;
        pc       = -1;
        run      = 0;
        played   = 1'b0;
        chart    = (prev_cur == 0) ? 0 : prev_cur - 1;
        was_hist = (state == history_page);
        arrow_keys = e.key;
        while (c < 6 || state == play_page) begin
            @(negedge prog_clk);
            c++;
            if (c == 2) arrow_keys = '0;  // held two cycles.
            if (state == play_page) begin
                played = 1'b1;
                pc++;
                // player steps begin one cycle after play_page.
                if (pc >= 1 && (pc - 1) % step_cycles == 0 &&
                    (pc - 1) / step_cycles < chart_len) begin
                    note = charts[chart][(pc - 1) / step_cycles];
                    case (e.mode)
                        hits_match: hit_keys = note;
                        hits_rand:  hit_keys = ($urandom % 2 == 1) ? note : lane_t'($urandom);
                        default:    hit_keys = '0;
                    endcase
                    if (note != '0 && (e.key == key_left || hit_keys == note)) run++;
                end
                if (pc == 2) check_val("auto_play", 64'(auto_play), 64'(e.key == key_left));
                if (pc == 20) arrow_keys = key_down;  // dropped during play.
                if (pc == 22) arrow_keys = '0;
            end
        end
        hit_keys = '0;
        if (played) begin
            for (int i = hist_depth - 1; i > 0; i--) hist_model[i] = hist_model[i-1];
            hist_model[0] = run;
            exp_last      = run;
        end else if (was_hist) begin
            if (e.key == key_down) rd_model = (rd_model + 1) % hist_depth;
            else if (e.key == key_up) rd_model = (rd_model + hist_depth - 1) % hist_depth;
        end
        if (e.score >= 0) exp_score = e.score;
        else if (e.st == history_page) exp_score = hist_model[rd_model];
        else exp_score = exp_last;
        check_val("state", 64'(state), 64'(e.st));
        check_val("cursor", 64'(cursor), 64'(e.cur));
        check_val("seg_label", seg_label, e.lbl);
        check_val("auto_play", 64'(auto_play), 64'(0));
        if (e.st == history_page) check_val("hist_score", 64'(hist_score), 64'(exp_score));
        else check_val("last_score", 64'(last_score), 64'(exp_score));
        prev_cur = int'(e.cur);
    endtask

    initial begin
        void'($urandom(90828));
        rst        = 1'b1;
        arrow_keys = '0;
        hit_keys   = '0;
        prev_cur   = 0;
        rd_model   = 0;
        exp_last   = 0;
        hist_model = '{default: 0};
        load_charts();
        build_table();
        repeat (4) @(posedge prog_clk);
        @(negedge prog_clk);
        rst = 1'b0;
        check_val("state", 64'(state), 64'(menu_page));
        check_val("cursor", 64'(cursor), 64'(0));
        check_val("seg_label", seg_label, "HIS     ");
        check_val("auto_play", 64'(auto_play), 64'(0));
        check_val("hist_score", 64'(hist_score), 64'(0));
        foreach (tbl[i]) run_entry(tbl[i]);
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== flist.f ====
hw/rg_pkg.sv
hw/play_if.sv
hw/game_ctrl.sv
hw/page_menu.sv
hw/chart_rom.sv
hw/note_player.sv
hw/score_history.sv
hw/rhythm_top.sv
test/tb_rhythm_top.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build folder and the log"

test:
	verilator --binary --timing -j 0 -f flist.f --top-module tb_rhythm_top -Mdir obj_dir
	./obj_dir/Vtb_rhythm_top | tee $(LOG)
	@grep -q "All checks passed" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
